// ==== include/video_bus_defines.svh ====
`ifndef VIDEO_BUS_DEFINES_SVH
`define VIDEO_BUS_DEFINES_SVH

// Display side stays parked until this many words are stored
// Half the buffer, so the first lines have some slack
`define PREFILL_WORDS 16

// Buffer depth in 30-bit pixel words
`define FIFO_DEPTH 32

// Width of the fill level count
// Must hold the value FIFO_DEPTH itself, not only DEPTH-1
`define FIFO_LEVEL_W 6

`endif

// ==== source/frame_prefill_gate.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "video_bus_defines.svh"

// Keeps the display side parked until the buffer holds data
// Counts real writes, not raw valid strobes
module frame_prefill_gate (
	input  wire  ctrl_clk,
	input  wire  reset_n,
	input  wire  accept,
	output logic display_run
);

	// Enough bits to reach the threshold itself
	localparam int CNT_W = $clog2(`PREFILL_WORDS + 1);

	logic [CNT_W-1:0] accepted;
	logic threshold_hit;

	// Count stops here, so no wrap back to zero
	assign threshold_hit = (accepted == CNT_W'(`PREFILL_WORDS));

	// Saturating count of accepted words
	always_ff @(posedge ctrl_clk)
	begin
		if (!reset_n)
			accepted <= '0;
		else if (accept && !threshold_hit)
			accepted <= accepted + 1'b1;
	end

	// Release flag, one cycle after the last prefill word lands
	// Only reset brings it back down
	always_ff @(posedge ctrl_clk)
	begin
		if (!reset_n)
			display_run <= 1'b0;
		else if (threshold_hit)
			display_run <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== source/pixel_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "video_bus_defines.svh"

// Show-ahead pixel buffer
// Head word is read straight out of the array, no read latency
module pixel_fifo #(
	parameter int DEPTH = `FIFO_DEPTH
) (
	input  wire        ctrl_clk,
	input  wire        reset_n,
	input  wire        pixel_valid,
	input  wire [29:0] pixel_data,
	output logic       accept,
	output logic       full,
	output logic       overflow,
	pixel_stream_if.source rd
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [29:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [`FIFO_LEVEL_W-1:0] level;
	logic do_pop;

	// Pointer advance with wrap, also for non power of two depth
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	// Flags come from the level only
	assign full     = (level == `FIFO_LEVEL_W'(DEPTH));
	assign rd.empty = (level == '0);
	assign rd.level = level;
	assign rd.word  = mem[rd_ptr];

	// Word offered while full is lost
	assign accept = pixel_valid & ~full;
	// Pop on empty is ignored
	assign do_pop = rd.pop & ~rd.empty;

	// Storage array
	always_ff @(posedge ctrl_clk)
	begin
		if (accept)
			mem[wr_ptr] <= pixel_data;
	end

	always_ff @(posedge ctrl_clk)
	begin
		if (!reset_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end
		else
		begin
			if (accept)
				wr_ptr <= ptr_next(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_next(rd_ptr);
			// Simultaneous push and pop leaves the level alone
			case ({accept, do_pop})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

	// Sticky drop flag
	always_ff @(posedge ctrl_clk)
	begin
		if (!reset_n)
			overflow <= 1'b0;
		else if (pixel_valid && full)
			overflow <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== source/pixel_formatter.sv ====
`timescale 1ns/1ps
`default_nettype none

// Pulls one word per active pixel and drives the 24-bit video port
// Never stalls the raster; a starved pixel goes out as black
module pixel_formatter (
	input  wire         ctrl_clk,
	input  wire         reset_n,
	input  wire         display_run,
	input  wire         de_raw,
	input  wire         hs_raw,
	input  wire         vs_raw,
	pixel_stream_if.sink rd,
	output logic        vpg_de,
	output logic        vpg_hs,
	output logic        vpg_vs,
	output logic [23:0] vpg_data,
	output logic        underflow
);

	logic pop_req;
	logic starved;
	logic [23:0] rgb24;

	// Show-ahead buffer, so pop and data share the cycle
	assign pop_req = display_run & de_raw;
	assign rd.pop  = pop_req;

	// Active pixel with nothing stored
	assign starved = pop_req & rd.empty;

	// Top 8 of each 10-bit channel, R G B from high to low
	assign rgb24 = {rd.word[29:22], rd.word[19:12], rd.word[9:2]};

	// One register stage for data, de and both syncs
	always_ff @(posedge ctrl_clk)
	begin
		if (!reset_n)
		begin
			vpg_de   <= 1'b0;
			vpg_hs   <= 1'b1;
			vpg_vs   <= 1'b1;
			vpg_data <= '0;
		end
		else
		begin
			vpg_de <= pop_req;
			vpg_hs <= hs_raw;
			vpg_vs <= vs_raw;
			// Blanking and starved pixels both show zero
			if (pop_req && !rd.empty)
				vpg_data <= rgb24;
			else
				vpg_data <= '0;
		end
	end

	// Sticky, cleared by reset only
	always_ff @(posedge ctrl_clk)
	begin
		if (!reset_n)
			underflow <= 1'b0;
		else if (starved)
			underflow <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== source/pixel_stream_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "video_bus_defines.svh"

// Read side of the pixel buffer
// word is valid whenever empty is low
interface pixel_stream_if;

	// Head of the buffer, show-ahead
	logic [29:0] word;
	logic empty;
	// Current fill count, 0 to FIFO_DEPTH
	logic [`FIFO_LEVEL_W-1:0] level;
	// Consume the head word this cycle
	logic pop;

	// Buffer side
	modport source (
		output word,
		output empty,
		output level,
		input  pop
	);

	// Consumer side
	modport sink (
		input  word,
		input  empty,
		input  level,
		output pop
	);

endinterface

`default_nettype wire

// ==== source/video_bus_pkg.sv ====
`default_nettype none

package video_bus_pkg;

	// Video mode select, one bit
	// Test mode is a tiny raster for short simulations
	typedef enum logic {
		MODE_VGA_640x480 = 1'b0,
		MODE_TEST_8x4    = 1'b1
	} video_mode_e;

	// Raster description for one mode
	// Counts start at zero on the first active pixel / line
	// Sync windows are [start, end), end exclusive
	typedef struct packed {
		// Horizontal axis, in pixel clocks
		logic [9:0] h_active;
		logic [9:0] h_sync_start;
		logic [9:0] h_sync_end;
		logic [9:0] h_total;
		// Vertical axis, in lines
		logic [9:0] v_active;
		logic [9:0] v_sync_start;
		logic [9:0] v_sync_end;
		logic [9:0] v_total;
	} mode_timing_t;

endpackage

`default_nettype wire

// ==== source/video_bus_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "video_bus_defines.svh"

// Camera to display pixel buffer, single clock
module video_bus_top (
	input  wire         ctrl_clk,
	input  wire         reset_n,

	// Sensor side, one-cycle strobe per word
	input  wire         pixel_valid,
	input  wire  [29:0] pixel_data,

	input  wire         video_bus_pkg::video_mode_e mode,

	// Video port
	output wire         vpg_de,
	output wire         vpg_hs,
	output wire         vpg_vs,
	output wire  [23:0] vpg_data,

	// Buffer status
	output wire         fifo_empty,
	output wire         fifo_full,
	output wire  [`FIFO_LEVEL_W-1:0] fifo_level,
	output wire         overflow,
	output wire         underflow
);

	wire accept;
	wire display_run;
	wire de_raw;
	wire hs_raw;
	wire vs_raw;

	// Buffer read side to formatter
	pixel_stream_if stream ();

	assign fifo_empty = stream.empty;
	assign fifo_level = stream.level;

	pixel_fifo #(
		.DEPTH(`FIFO_DEPTH)
	) u_fifo (
		.ctrl_clk   (ctrl_clk),
		.reset_n    (reset_n),
		.pixel_valid(pixel_valid),
		.pixel_data (pixel_data),
		.accept     (accept),
		.full       (fifo_full),
		.overflow   (overflow),
		.rd         (stream.source)
	);

	// Startup guard, counts words actually stored
	frame_prefill_gate u_gate (
		.ctrl_clk   (ctrl_clk),
		.reset_n    (reset_n),
		.accept     (accept),
		.display_run(display_run)
	);

	video_timing_gen u_timing (
		.ctrl_clk   (ctrl_clk),
		.reset_n    (reset_n),
		.display_run(display_run),
		.mode       (mode),
		.de_raw     (de_raw),
		.hs_raw     (hs_raw),
		.vs_raw     (vs_raw)
	);

	pixel_formatter u_fmt (
		.ctrl_clk   (ctrl_clk),
		.reset_n    (reset_n),
		.display_run(display_run),
		.de_raw     (de_raw),
		.hs_raw     (hs_raw),
		.vs_raw     (vs_raw),
		.rd         (stream.sink),
		.vpg_de     (vpg_de),
		.vpg_hs     (vpg_hs),
		.vpg_vs     (vpg_vs),
		.vpg_data   (vpg_data),
		.underflow  (underflow)
	);

endmodule

`default_nettype wire

// ==== source/video_timing_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

// Raster counters and raw de / hs / vs for the selected mode
// Outputs are registered, one cycle behind the counters
module video_timing_gen (
	input  wire  ctrl_clk,
	input  wire  reset_n,
	input  wire  display_run,
	input  wire  video_bus_pkg::video_mode_e mode,
	output logic de_raw,
	output logic hs_raw,
	output logic vs_raw
);

	import video_bus_pkg::*;

	mode_timing_t timing_q;
	mode_timing_t timing;
	logic [9:0] h_cnt;
	logic [9:0] v_cnt;
	logic frame_start;
	logic line_end;
	logic frame_end;
	logic h_active;
	logic v_active;
	logic h_sync;
	logic v_sync;

	// Raster table
	function automatic mode_timing_t timing_of(input video_mode_e m);
		mode_timing_t t;
		case (m)
			MODE_TEST_8x4:
			begin
				t.h_active     = 10'd8;
				t.h_sync_start = 10'd9;
				t.h_sync_end   = 10'd11;
				t.h_total      = 10'd12;
				t.v_active     = 10'd4;
				t.v_sync_start = 10'd5;
				t.v_sync_end   = 10'd6;
				t.v_total      = 10'd6;
			end
			default:
			begin
				// 640 + 16 fp + 96 sync + 48 bp
				t.h_active     = 10'd640;
				t.h_sync_start = 10'd656;
				t.h_sync_end   = 10'd752;
				t.h_total      = 10'd800;
				// 480 + 10 fp + 2 sync + 33 bp
				t.v_active     = 10'd480;
				t.v_sync_start = 10'd490;
				t.v_sync_end   = 10'd492;
				t.v_total      = 10'd525;
			end
		endcase
		return t;
	endfunction

	// Mode takes effect at the top of each frame
	// During the first cycle of a frame use the fresh lookup directly
	assign frame_start = (h_cnt == '0) && (v_cnt == '0);
	assign timing      = frame_start ? timing_of(mode) : timing_q;

	assign line_end  = (h_cnt == timing.h_total - 10'd1);
	assign frame_end = (v_cnt == timing.v_total - 10'd1);

	// Window decode
	assign h_active = (h_cnt < timing.h_active);
	assign v_active = (v_cnt < timing.v_active);
	assign h_sync   = (h_cnt >= timing.h_sync_start) && (h_cnt < timing.h_sync_end);
	assign v_sync   = (v_cnt >= timing.v_sync_start) && (v_cnt < timing.v_sync_end);

	// Latched mode timing for the rest of the frame
	always_ff @(posedge ctrl_clk)
	begin
		if (!reset_n)
			timing_q <= timing_of(MODE_VGA_640x480);
		else if (frame_start)
			timing_q <= timing;
	end

	// Counters parked at the origin until the display side is released
	always_ff @(posedge ctrl_clk)
	begin
		if (!reset_n || !display_run)
		begin
			h_cnt <= '0;
			v_cnt <= '0;
		end
		else if (line_end)
		begin
			h_cnt <= '0;
			v_cnt <= frame_end ? 10'd0 : v_cnt + 10'd1;
		end
		else
			h_cnt <= h_cnt + 10'd1;
	end

	// Syncs active low
	always_ff @(posedge ctrl_clk)
	begin
		if (!reset_n)
		begin
			de_raw <= 1'b0;
			hs_raw <= 1'b1;
			vs_raw <= 1'b1;
		end
		else
		begin
			de_raw <= display_run && h_active && v_active;
			hs_raw <= !(display_run && h_sync);
			vs_raw <= !(display_run && v_sync);
		end
	end

endmodule

`default_nettype wire

// ==== verification/tb_video_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "video_bus_defines.svh"

module tb_video_bus;

	import video_bus_pkg::*;

	// Output select for edge waits
	localparam int SEL_DE = 0;
	localparam int SEL_HS = 1;
	localparam int SEL_VS = 2;

	logic ctrl_clk;
	logic reset_n;
	logic pixel_valid;
	logic [29:0] pixel_data;
	video_mode_e mode;
	logic vpg_de;
	logic vpg_hs;
	logic vpg_vs;
	logic [23:0] vpg_data;
	logic fifo_empty;
	logic fifo_full;
	logic [`FIFO_LEVEL_W-1:0] fifo_level;
	logic overflow;
	logic underflow;

	// Words stored by the buffer and not yet seen on the video port
	logic [29:0] model [$];
	int checks = 0;
	int errors = 0;
	int pixels_seen = 0;
	int starved_seen = 0;

	video_bus_top i_dut (
		.ctrl_clk   (ctrl_clk),
		.reset_n    (reset_n),
		.pixel_valid(pixel_valid),
		.pixel_data (pixel_data),
		.mode       (mode),
		.vpg_de     (vpg_de),
		.vpg_hs     (vpg_hs),
		.vpg_vs     (vpg_vs),
		.vpg_data   (vpg_data),
		.fifo_empty (fifo_empty),
		.fifo_full  (fifo_full),
		.fifo_level (fifo_level),
		.overflow   (overflow),
		.underflow  (underflow)
	);

	// 50 MHz
	initial
	begin
		ctrl_clk = 1'b0;
		forever #10 ctrl_clk = ~ctrl_clk;
	end

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("[ERROR] %0t ns %s expected %0h actual %0h", $time, name, expected, actual);
		end
	endtask

	function automatic logic [29:0] rand_word();
		logic [31:0] r;
		r = $urandom();
		return r[29:0];
	endfunction

	// Upper 8 bits of each 10-bit channel
	function automatic logic [23:0] rgb_of(input logic [29:0] w);
		return {w[29:22], w[19:12], w[9:2]};
	endfunction

	function automatic logic video_sig(input int sel);
		case (sel)
			SEL_DE:  return vpg_de;
			SEL_HS:  return vpg_hs;
			default: return vpg_vs;
		endcase
	endfunction

	// One falling edge: check the shown pixel, then drive the next input
	task automatic step(input logic valid, input logic [29:0] data);
		logic [23:0] expect_rgb;
		@(negedge ctrl_clk);
		if (vpg_de)
		begin
			pixels_seen++;
			if (model.size() > 0)
				expect_rgb = rgb_of(model.pop_front());
			else
			begin
				// Starved pixel goes out black
				expect_rgb = '0;
				starved_seen++;
			end
			compare("vpg_data", 32'(expect_rgb), 32'(vpg_data));
		end
		pixel_valid = valid;
		pixel_data  = data;
		// Full at this edge means the word is lost at the next rising edge
		if (valid && !fifo_full)
			model.push_back(data);
	endtask

	// Keep the buffer topped up, well clear of full
	task automatic feed_step();
		if (fifo_level < `FIFO_LEVEL_W'(`FIFO_DEPTH - 8))
			step(1'b1, rand_word());
		else
			step(1'b0, '0);
	endtask

	task automatic wait_edge(input int sel, input string name, input logic rising,
		input int limit, input logic feed, output int steps);
		logic prev;
		logic cur;
		cur = video_sig(sel);
		steps = 0;
		while (steps < limit)
		begin
			prev = cur;
			if (feed)
				feed_step();
			else
				step(1'b0, '0);
			steps++;
			cur = video_sig(sel);
			if (rising ? (!prev && cur) : (prev && !cur))
				return;
		end
		errors++;
		$display("Timed out after %0d cycles waiting for an edge on %s", limit, name);
	endtask

	// Two rising edges in reset, released on a falling edge
	task automatic reset_dut(input video_mode_e m);
		@(negedge ctrl_clk);
		reset_n     = 1'b0;
		pixel_valid = 1'b0;
		pixel_data  = '0;
		mode        = m;
		model.delete();
		repeat (2) @(negedge ctrl_clk);
		reset_n = 1'b1;
	endtask

	task automatic reset_values();
		reset_dut(MODE_TEST_8x4);
		compare("vpg_de", 0, 32'(vpg_de));
		compare("vpg_hs", 1, 32'(vpg_hs));
		compare("vpg_vs", 1, 32'(vpg_vs));
		compare("fifo_empty", 1, 32'(fifo_empty));
		compare("fifo_full", 0, 32'(fifo_full));
		compare("fifo_level", 0, 32'(fifo_level));
		compare("overflow", 0, 32'(overflow));
		compare("underflow", 0, 32'(underflow));
	endtask

	task automatic prefill_release();
		int i;
		int steps;
		reset_dut(MODE_TEST_8x4);
		repeat (`PREFILL_WORDS - 1) step(1'b1, rand_word());
		// One word short, display stays parked
		for (i = 0; i < 100; i++)
		begin
			step(1'b0, '0);
			compare("vpg_de", 0, 32'(vpg_de));
		end
		step(1'b1, rand_word());
		// Accept edge, run one later, first pixel two after that
		wait_edge(SEL_DE, "vpg_de", 1'b1, 20, 1'b0, steps);
		compare("cycles to first pixel", 4, steps);
	endtask

	task automatic data_order();
		int seen_before;
		seen_before = pixels_seen;
		repeat (300) feed_step();
		compare("enough pixels shown", 1, 32'(pixels_seen - seen_before >= 64));
		compare("underflow", 0, 32'(underflow));
		compare("starved pixels", 0, starved_seen);
	endtask

	task automatic raster_timing();
		int i;
		int steps;
		int run;
		int de_runs;
		int hs_low;
		int hs_falls;
		int vs_low;
		logic prev_de;
		logic prev_hs;
		// Frame origin shows as vs rising, with the first pixel alongside
		wait_edge(SEL_VS, "vpg_vs", 1'b1, 200, 1'b1, steps);
		run = 0;
		de_runs = 0;
		hs_low = 0;
		hs_falls = 0;
		vs_low = 0;
		prev_de = 1'b0;
		prev_hs = 1'b1;
		// 12 x 6 test raster
		for (i = 0; i < 72; i++)
		begin
			if (i > 0)
				feed_step();
			if (vpg_de)
				run++;
			else if (prev_de)
			begin
				compare("de cycles per line", 8, run);
				run = 0;
			end
			if (vpg_de && !prev_de)
				de_runs++;
			if (!vpg_hs)
				hs_low++;
			if (!vpg_hs && prev_hs)
				hs_falls++;
			if (!vpg_vs)
				vs_low++;
			prev_de = vpg_de;
			prev_hs = vpg_hs;
		end
		compare("active lines per frame", 4, de_runs);
		compare("hs low cycles per frame", 12, hs_low);
		compare("hs pulses per frame", 6, hs_falls);
		compare("vs low cycles per frame", 12, vs_low);

		// VGA takes over at the next frame origin
		mode = MODE_VGA_640x480;
		feed_step();
		wait_edge(SEL_VS, "vpg_vs", 1'b1, 200, 1'b1, steps);
		compare("vpg_de at frame origin", 1, 32'(vpg_de));
		wait_edge(SEL_DE, "vpg_de", 1'b0, 1000, 1'b1, steps);
		compare("vga de cycles per line", 640, steps);
		wait_edge(SEL_HS, "vpg_hs", 1'b0, 1000, 1'b1, steps);
		wait_edge(SEL_HS, "vpg_hs", 1'b0, 1000, 1'b1, steps);
		compare("vga hs period", 800, steps);
	endtask

	task automatic overflow_drop();
		int i;
		logic hit;
		reset_dut(MODE_TEST_8x4);
		hit = 1'b0;
		i = 0;
		// Writes outpace the raster, so the buffer fills
		while (!hit && i < 200)
		begin
			step(1'b1, rand_word());
			hit = fifo_full;
			i++;
		end
		if (!hit)
		begin
			errors++;
			$display("fifo_full never rose while writing every cycle");
		end
		else
		begin
			compare("fifo_level", `FIFO_DEPTH, 32'(fifo_level));
			// Word offered while full stays out of the model
			compare("model words", `FIFO_DEPTH, model.size());
			step(1'b0, '0);
			compare("overflow", 1, 32'(overflow));
		end
	endtask

	task automatic underflow_drain();
		int i;
		int starved_before;
		starved_before = starved_seen;
		i = 0;
		// No more writes, raster keeps pulling
		while (!underflow && i < 400)
		begin
			step(1'b0, '0);
			i++;
		end
		if (!underflow)
		begin
			errors++;
			$display("underflow never rose after the buffer drained");
		end
		else
		begin
			compare("vpg_de", 1, 32'(vpg_de));
			compare("vpg_data", 0, 32'(vpg_data));
			compare("fifo_empty", 1, 32'(fifo_empty));
			compare("starved pixels", 1, 32'(starved_seen > starved_before));
			compare("model words left", 0, model.size());
		end
	endtask

	initial
	begin
		void'($urandom(87846));
		reset_n     = 1'b0;
		pixel_valid = 1'b0;
		pixel_data  = '0;
		mode        = MODE_TEST_8x4;

		reset_values();
		prefill_release();
		data_order();
		raster_timing();
		overflow_drop();
		underflow_drain();

		$display("checks %0d, errors %0d, assertion failures %0d",
			checks, errors, i_dut.u_checker.fail_count);
		if (errors == 0 && i_dut.u_checker.fail_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/video_bus_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "video_bus_defines.svh"

// Protocol rules on the top-level status and video ports
module video_bus_checker (
	input wire                     ctrl_clk,
	input wire                     reset_n,
	input wire                     fifo_full,
	input wire                     fifo_empty,
	input wire [`FIFO_LEVEL_W-1:0] fifo_level,
	input wire                     vpg_de,
	input wire [23:0]              vpg_data,
	input wire                     overflow,
	input wire                     underflow
);

	// Failed assertions so far, read back by the testbench
	int fail_count = 0;

	// Flags both derive from one level count
	full_empty_exclusive: assert property (@(posedge ctrl_clk) disable iff (!reset_n)
		!(fifo_full && fifo_empty))
	else
	begin
		fail_count++;
		$error("fifo_full and fifo_empty high in the same cycle");
	end

	// Level can reach the depth but never pass it
	level_in_range: assert property (@(posedge ctrl_clk) disable iff (!reset_n)
		fifo_level <= `FIFO_DEPTH)
	else
	begin
		fail_count++;
		$error("fifo_level above buffer depth: %0d", fifo_level);
	end

	// Blanking shows black
	blank_is_black: assert property (@(posedge ctrl_clk) disable iff (!reset_n)
		!vpg_de |-> (vpg_data == 24'd0))
	else
	begin
		fail_count++;
		$error("vpg_data nonzero outside active video: %06h", vpg_data);
	end

	// Sticky flags only drop after a reset cycle
	overflow_sticky: assert property (@(posedge ctrl_clk)
		$past(reset_n) |-> !$fell(overflow))
	else
	begin
		fail_count++;
		$error("overflow cleared without reset");
	end

	underflow_sticky: assert property (@(posedge ctrl_clk)
		$past(reset_n) |-> !$fell(underflow))
	else
	begin
		fail_count++;
		$error("underflow cleared without reset");
	end

endmodule

bind video_bus_top video_bus_checker u_checker (
	.ctrl_clk  (ctrl_clk),
	.reset_n   (reset_n),
	.fifo_full (fifo_full),
	.fifo_empty(fifo_empty),
	.fifo_level(fifo_level),
	.vpg_de    (vpg_de),
	.vpg_data  (vpg_data),
	.overflow  (overflow),
	.underflow (underflow)
);

`default_nettype wire

// ==== verilog.f ====
+incdir+include
source/video_bus_pkg.sv
source/pixel_stream_if.sv
source/frame_prefill_gate.sv
source/pixel_fifo.sv
source/video_timing_gen.sv
source/pixel_formatter.sv
source/video_bus_top.sv
verification/video_bus_checker.sv
verification/tb_video_bus.sv
